//--- src/isa_pkg.sv
// RV32I encodings for the subset renamed here. No CSR, FENCE, JALR or AUIPC.
// The instruction word is one packed union. The decoder picks the view by opcode.
package isa_pkg;

    // major opcodes, bits [6:0]
    typedef enum logic [6:0] {
        OP     = 7'b0110011,  // reg-reg alu
        OP_IMM = 7'b0010011,  // reg-imm alu
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        LUI    = 7'b0110111,
        JAL    = 7'b1101111
    } opcode_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;   // imm[11:0], sign in bit 11
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    // also carries B-type, bit order differs, see decoder
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_fmt_t;

    // also carries J-type in imm20
    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        u_fmt_t u_fmt;
    } instr_word_u;

endpackage

//--- src/rename_pkg.sv
// Rename-side types. The tag width is fixed at 3 bits, so at most 8 ROB slots.
// A source tag is meaningful only while its pending bit is set.
package rename_pkg;

    localparam int ROB_TAG_W = 3;

    typedef logic [ROB_TAG_W-1:0] rob_tag_t;
    typedef logic [4:0]           arch_reg_t;

    // one status table entry
    typedef struct packed {
        logic     busy;  // an uncommitted writer exists
        rob_tag_t tag;   // most recent writer
    } reg_stat_t;

    // source operand as a reservation station sees it
    typedef struct packed {
        arch_reg_t reg_idx;
        logic      pending;  // value not yet produced
        rob_tag_t  tag;      // producer, zero when not pending
    } src_operand_t;

    // stage 1 output
    typedef struct packed {
        isa_pkg::opcode_e op;
        logic [2:0]       funct3;
        logic             funct7_bit5;  // sub/sra select
        arch_reg_t        rs1;
        arch_reg_t        rs2;
        arch_reg_t        rd;
        logic             uses_rs1;
        logic             uses_rs2;
        logic             writes_rd;
        logic [31:0]      imm;          // sign-extended, zero for OP
    } decoded_uop_t;

    // stage 2 output
    typedef struct packed {
        decoded_uop_t uop;
        rob_tag_t     rob_tag;
        src_operand_t src1;
        src_operand_t src2;
    } issue_uop_t;

    typedef struct packed {
        arch_reg_t rd;
        logic      writes_rd;
        rob_tag_t  tag;
    } commit_t;

endpackage

//--- src/instr_decode.sv
// Stage 1. One output register, no skid buffer. in_ready drops while the register is held.
// Unknown opcodes decode to a micro-op with no sources and no destination.
module instr_decode import isa_pkg::*, rename_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         flush,
    input  logic         in_valid,
    output logic         in_ready,
    input  instr_word_u  in_word,
    output logic         uop_valid,
    input  logic         uop_ready,
    output decoded_uop_t uop
);

    decoded_uop_t dec;  // combinational decode of in_word

    always_comb begin
        dec = '0;
        dec.op = in_word.r_fmt.opcode;
        case (in_word.r_fmt.opcode)
            OP: begin
                dec.funct3      = in_word.r_fmt.funct3;
                dec.funct7_bit5 = in_word.r_fmt.funct7[5];
                dec.rs1         = in_word.r_fmt.rs1;
                dec.rs2         = in_word.r_fmt.rs2;
                dec.rd          = in_word.r_fmt.rd;
                dec.uses_rs1    = 1'b1;
                dec.uses_rs2    = 1'b1;
                dec.writes_rd   = 1'b1;
            end
            OP_IMM, LOAD: begin
                dec.funct3    = in_word.i_fmt.funct3;
                // bit 30 picks srai over srli, meaningless for loads
                dec.funct7_bit5 = (in_word.i_fmt.opcode == OP_IMM) & in_word.r_fmt.funct7[5];
                dec.rs1       = in_word.i_fmt.rs1;
                dec.rd        = in_word.i_fmt.rd;
                dec.uses_rs1  = 1'b1;
                dec.writes_rd = 1'b1;
                dec.imm       = {{20{in_word.i_fmt.imm12[11]}}, in_word.i_fmt.imm12};
            end
            STORE: begin
                dec.funct3   = in_word.s_fmt.funct3;
                dec.rs1      = in_word.s_fmt.rs1;
                dec.rs2      = in_word.s_fmt.rs2;
                dec.uses_rs1 = 1'b1;
                dec.uses_rs2 = 1'b1;
                dec.imm      = {{20{in_word.s_fmt.imm_hi[6]}}, in_word.s_fmt.imm_hi,
                                in_word.s_fmt.imm_lo};
            end
            BRANCH: begin
                dec.funct3   = in_word.s_fmt.funct3;
                dec.rs1      = in_word.s_fmt.rs1;
                dec.rs2      = in_word.s_fmt.rs2;
                dec.uses_rs1 = 1'b1;
                dec.uses_rs2 = 1'b1;
                // B-type reshuffle: imm[12|10:5] in hi, imm[4:1|11] in lo
                dec.imm      = {{20{in_word.s_fmt.imm_hi[6]}}, in_word.s_fmt.imm_lo[0],
                                in_word.s_fmt.imm_hi[5:0], in_word.s_fmt.imm_lo[4:1], 1'b0};
            end
            LUI: begin
                dec.rd        = in_word.u_fmt.rd;
                dec.writes_rd = 1'b1;
                dec.imm       = {in_word.u_fmt.imm20, 12'b0};
            end
            JAL: begin
                dec.rd        = in_word.u_fmt.rd;
                dec.writes_rd = 1'b1;  // link register
                // J-type: imm[20|10:1|11|19:12]
                dec.imm       = {{12{in_word.u_fmt.imm20[19]}}, in_word.u_fmt.imm20[7:0],
                                 in_word.u_fmt.imm20[8], in_word.u_fmt.imm20[18:9], 1'b0};
            end
            default: ;  // unsupported, flags stay low
        endcase
    end

    assign in_ready = ~flush & (~uop_valid | uop_ready);  // empty or draining this edge

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            uop_valid <= 1'b0;
        end else if (flush) begin
            uop_valid <= 1'b0;
        end else if (in_ready) begin
            uop_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) uop <= dec;  // payload only
    end

    // held micro-op must not change under back-pressure
    a_uop_stable: assert property (@(posedge clk) disable iff (reset)
        uop_valid && !uop_ready |=> $stable(uop));

endmodule

//--- src/rob_tag_alloc.sv
// In-order ROB tag ring. Tags go out at the head and come back oldest first on commit.
// ROB_DEPTH must not exceed 2**ROB_TAG_W. Flush returns every slot.
module rob_tag_alloc import rename_pkg::*; #(
    parameter int ROB_DEPTH = 8
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush,
    input  logic     tag_take,
    input  logic     commit_valid,
    output logic     tag_avail,
    output rob_tag_t next_tag
);

    localparam int                 CNT_W     = ROB_TAG_W + 1;
    localparam logic [CNT_W-1:0]   DEPTH_CNT = CNT_W'(ROB_DEPTH);
    localparam rob_tag_t           LAST_TAG  = rob_tag_t'(ROB_DEPTH - 1);

    rob_tag_t         head;       // next tag to hand out
    logic [CNT_W-1:0] used_cnt;   // slots in flight

    assign tag_avail = (used_cnt != DEPTH_CNT);
    assign next_tag  = head;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            head     <= '0;
            used_cnt <= '0;
        end else if (flush) begin
            head     <= '0;  // restart at tag 0
            used_cnt <= '0;
        end else begin
            if (tag_take) begin
                head <= (head == LAST_TAG) ? '0 : head + 1'b1;  // wrap at depth
            end
            case ({tag_take, commit_valid})
                2'b10:   used_cnt <= used_cnt + 1'b1;
                2'b01:   used_cnt <= used_cnt - 1'b1;
                default: ;  // both or neither, count unchanged
            endcase
        end
    end

    // ROB may only retire what was handed out
    a_commit_nonempty: assert property (@(posedge clk) disable iff (reset)
        commit_valid |-> used_cnt != '0);

    // rename must wait for a free slot
    a_take_avail: assert property (@(posedge clk) disable iff (reset)
        tag_take |-> tag_avail);

endmodule

//--- src/reg_status_table.sv
// Stage 2. Register status table plus the issue register.
// x0 has no entry and never reads busy. A commit clears an entry only if its tag is still
// the latest writer. An issue write to the same rd on the same edge wins over the clear.
module reg_status_table import rename_pkg::*; #(
    parameter int ROB_DEPTH = 8
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         flush,
    input  logic         uop_valid,
    output logic         uop_ready,
    input  decoded_uop_t uop,
    input  logic         tag_avail,
    input  rob_tag_t     next_tag,
    output logic         tag_take,
    input  logic         commit_valid,
    input  commit_t      commit,
    output logic         issue_valid,
    input  logic         issue_ready,
    output issue_uop_t   issue
);

    reg_stat_t    stat [1:31];     // x0 implicit
    logic         can_move;        // issue register free or draining
    logic         capture;
    logic         clr_hit;         // commit matches the latest writer
    logic         tag_range_err;
    src_operand_t src1;
    src_operand_t src2;

    // pending status of one source, with same-edge commit bypass
    function automatic src_operand_t lookup(arch_reg_t r, logic used);
        src_operand_t s;
        s = '0;
        s.reg_idx = r;
        if (used && r != '0) begin
            if (stat[r].busy &&
                !(commit_valid && commit.writes_rd && commit.rd == r &&
                  commit.tag == stat[r].tag)) begin
                s.pending = 1'b1;
                s.tag     = stat[r].tag;
            end
        end
        return s;
    endfunction

    assign can_move  = ~issue_valid | issue_ready;
    assign uop_ready = tag_avail & can_move & ~flush;
    assign capture   = uop_valid & uop_ready;
    assign tag_take  = capture;  // one tag per captured micro-op

    always_comb begin
        src1 = lookup(uop.rs1, uop.uses_rs1);
        src2 = lookup(uop.rs2, uop.uses_rs2);
    end

    always_comb begin
        clr_hit = 1'b0;
        if (commit_valid && commit.writes_rd && commit.rd != '0) begin
            clr_hit = stat[commit.rd].busy && (stat[commit.rd].tag == commit.tag);
        end
    end

    // table update, clear first so a same-edge issue write overrides it
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) stat[i] <= '0;
        end else if (flush) begin
            for (int i = 1; i < 32; i++) stat[i] <= '0;
        end else begin
            if (clr_hit) stat[commit.rd].busy <= 1'b0;
            if (capture && uop.writes_rd && uop.rd != '0) begin
                stat[uop.rd].busy <= 1'b1;
                stat[uop.rd].tag  <= next_tag;  // now the latest writer
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            issue_valid <= 1'b0;
        end else if (flush) begin
            issue_valid <= 1'b0;
        end else if (can_move) begin
            issue_valid <= capture;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            issue.uop     <= uop;
            issue.rob_tag <= next_tag;
            issue.src1    <= src1;
            issue.src2    <= src2;
        end
    end

    // a busy entry holding a tag past the ring end means allocator and table disagree
    always_comb begin
        tag_range_err = 1'b0;
        for (int i = 1; i < 32; i++) begin
            if (stat[i].busy && int'(stat[i].tag) >= ROB_DEPTH) tag_range_err = 1'b1;
        end
    end

    a_tag_range: assert property (@(posedge clk) disable iff (reset) !tag_range_err);

endmodule

//--- src/issue_stage_top.sv
// Issue-side rename: decode, then tag allocation with status lookup.
// Latency is two cycles from input accept to issue_valid when issue_ready is high.
// ROB_DEPTH is at most 8. Commits must arrive oldest tag first.
module issue_stage_top import rename_pkg::*, isa_pkg::*; #(
    parameter int ROB_DEPTH = 8
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        flush,         // mispredict, single cycle
    input  logic        in_valid,
    output logic        in_ready,
    input  instr_word_u in_word,
    output logic        issue_valid,
    input  logic        issue_ready,
    output issue_uop_t  issue,
    input  logic        commit_valid,  // always accepted
    input  commit_t     commit
);

    logic         uop_valid;
    logic         uop_ready;
    decoded_uop_t uop;
    logic         tag_avail;
    logic         tag_take;
    rob_tag_t     next_tag;

    instr_decode u_decode (
        .clk,
        .reset,
        .flush,
        .in_valid,
        .in_ready,
        .in_word,
        .uop_valid,
        .uop_ready,
        .uop
    );

    rob_tag_alloc #(.ROB_DEPTH(ROB_DEPTH)) u_tag_alloc (
        .clk,
        .reset,
        .flush,
        .tag_take,
        .commit_valid,
        .tag_avail,
        .next_tag
    );

    reg_status_table #(.ROB_DEPTH(ROB_DEPTH)) u_status (
        .clk,
        .reset,
        .flush,
        .uop_valid,
        .uop_ready,
        .uop,
        .tag_avail,
        .next_tag,
        .tag_take,
        .commit_valid,
        .commit,
        .issue_valid,
        .issue_ready,
        .issue
    );

endmodule

//--- bench/tb_clock.sv
// Free-running testbench clock, 10 ns period, low at time zero.
module tb_clock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial clk = 1'b0;

    always #5 clk = ~clk;  // half period

endmodule

//--- bench/issue_ref_model.svh
// Reference model of the issue stage, included inside the testbench module.
// Tags wrap by the 3-bit width, so the model only fits a ROB depth of 8.
`ifndef ISSUE_REF_MODEL_SVH
`define ISSUE_REF_MODEL_SVH

logic     m_busy [32];  // index 0 never set
rob_tag_t m_tag  [32];
rob_tag_t m_head;       // next tag the ring hands out

// field extraction straight from the RV32I bit positions
function automatic decoded_uop_t model_decode(logic [31:0] w);
    decoded_uop_t d;
    d    = '0;
    d.op = opcode_e'(w[6:0]);
    case (d.op)
        OP:            {d.uses_rs1, d.uses_rs2, d.writes_rd} = 3'b111;
        OP_IMM, LOAD:  {d.uses_rs1, d.uses_rs2, d.writes_rd} = 3'b101;
        STORE, BRANCH: {d.uses_rs1, d.uses_rs2, d.writes_rd} = 3'b110;
        default:       {d.uses_rs1, d.uses_rs2, d.writes_rd} = 3'b001;  // lui, jal
    endcase
    d.rs1         = d.uses_rs1 ? w[19:15] : 5'd0;
    d.rs2         = d.uses_rs2 ? w[24:20] : 5'd0;
    d.rd          = d.writes_rd ? w[11:7] : 5'd0;
    d.funct3      = (d.op inside {LUI, JAL}) ? 3'b000 : w[14:12];
    d.funct7_bit5 = (d.op inside {OP, OP_IMM}) & w[30];
    case (d.op)
        OP_IMM, LOAD: d.imm = {{20{w[31]}}, w[31:20]};
        STORE:        d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
        BRANCH:       d.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        LUI:          d.imm = {w[31:12], 12'b0};
        JAL:          d.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        default:      d.imm = '0;  // reg-reg has no immediate
    endcase
    return d;
endfunction

function automatic src_operand_t model_src(arch_reg_t r, logic used);
    src_operand_t s;
    s         = '0;
    s.reg_idx = r;
    if (used && r != 5'd0 && m_busy[r]) begin
        s.pending = 1'b1;
        s.tag     = m_tag[r];  // latest uncommitted writer
    end
    return s;
endfunction

function automatic void model_flush();
    foreach (m_busy[i]) m_busy[i] = 1'b0;
    m_head = '0;  // ring restarts at tag 0
endfunction

// one rising edge, clear applied before the lookup so a committing source reads free
function automatic void model_edge(input logic cv, input commit_t c, input logic cap,
                                   input logic [31:0] w, output issue_uop_t e);
    e = '0;
    if (cv && c.writes_rd && c.rd != 5'd0 && m_busy[c.rd] && m_tag[c.rd] == c.tag) begin
        m_busy[c.rd] = 1'b0;
    end
    if (cap) begin
        e.uop     = model_decode(w);
        e.rob_tag = m_head;
        e.src1    = model_src(e.uop.rs1, e.uop.uses_rs1);
        e.src2    = model_src(e.uop.rs2, e.uop.uses_rs2);
        if (e.uop.writes_rd && e.uop.rd != 5'd0) begin  // new writer beats the clear
            m_busy[e.uop.rd] = 1'b1;
            m_tag[e.uop.rd]  = m_head;
        end
        m_head = m_head + 1'b1;
    end
endfunction

`endif

//--- bench/issue_tb.sv
// Testbench for the issue stage with ROB depth 8 and a seeded random stream.
// Inputs change on the falling edge and the model follows each rising edge.
module issue_tb import isa_pkg::*, rename_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ROB_DEPTH = 8;
    localparam int N_RAND    = 400;
    localparam int N_TOTAL   = N_RAND + 4 + 10 + 40;  // words over all tests

    logic        clk;
    logic        reset;
    logic        flush;
    logic        in_valid;
    logic        in_ready;
    instr_word_u in_word;
    logic        issue_valid;
    logic        issue_ready;
    issue_uop_t  issue;
    logic        commit_valid;
    commit_t     commit;

    integer      seed = 32'hf800;
    int          errors;
    int          checks;
    int          issued;      // issue transfers so far
    int          in_flight;   // tags taken and not committed
    int          ready_pct;   // chance of issue_ready per cycle
    int          commit_pct;  // chance of a commit per cycle
    logic [31:0] acc_q [$];   // accepted words not yet captured
    issue_uop_t  exp_q [$];   // captured, waiting for the issue transfer
    commit_t     cmt_q [$];   // issued, oldest first

    `include "issue_ref_model.svh"

    tb_clock u_clock (.clk);

    issue_stage_top #(.ROB_DEPTH(ROB_DEPTH)) i_issue_stage_top (.*);

    task automatic note_failure(input string msg);
        errors++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    function automatic logic [31:0] random_word();
        opcode_e     ops [7] = '{OP, OP_IMM, LOAD, STORE, BRANCH, LUI, JAL};
        logic [31:0] w;
        int          idx;
        w           = $random(seed);
        idx         = $unsigned($random(seed)) % 7;
        w[6:0]      = ops[idx];
        w[11:10]    = 2'b00;  // registers x0..x7 so dependencies are common
        w[19:18]    = 2'b00;
        w[24:23]    = 2'b00;
        return w;
    endfunction

    function automatic logic [31:0] addi_word(logic [4:0] rd, logic [4:0] rs1);
        return {12'h001, rs1, 3'b000, rd, OP_IMM};
    endfunction

    function automatic logic [31:0] add_word(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        return {7'b0, rs2, rs1, 3'b000, rd, OP};
    endfunction

    // compare one transfer with the oldest expected micro-op
    task automatic take_issue(input issue_uop_t got);
        issue_uop_t exp;
        assert (exp_q.size() > 0) else note_failure("an issue transfer came with nothing expected");
        if (exp_q.size() == 0) return;
        exp = exp_q.pop_front();
        checks++;
        issued++;
        assert (got.uop == exp.uop) else begin
            errors++;
            $display("MISMATCH at %0t ns: uop got %h expected %h", $time, got.uop, exp.uop);
        end
        assert (got.rob_tag == exp.rob_tag) else begin
            errors++;
            $display("MISMATCH at %0t ns: rob_tag got %0d expected %0d", $time,
                     got.rob_tag, exp.rob_tag);
        end
        assert (got.src1 == exp.src1) else begin
            errors++;
            $display("MISMATCH at %0t ns: src1 got %h expected %h", $time, got.src1, exp.src1);
        end
        assert (got.src2 == exp.src2) else begin
            errors++;
            $display("MISMATCH at %0t ns: src2 got %h expected %h", $time, got.src2, exp.src2);
        end
        cmt_q.push_back(commit_t'{rd: exp.uop.rd, writes_rd: exp.uop.writes_rd,
                                  tag: exp.rob_tag});
    endtask

    // one cycle from falling edge to falling edge
    task automatic step(input logic f, input logic iv, input logic [31:0] w, output bit took);
        logic        s_move;
        logic        s_xfer;
        logic        cap;
        logic [31:0] cw;
        issue_uop_t  s_issue;
        issue_uop_t  e;
        flush        = f;
        in_valid     = iv;
        in_word      = w;
        issue_ready  = ($unsigned($random(seed)) % 100) < ready_pct;
        commit_valid = !f && cmt_q.size() > 0 &&
                       ($unsigned($random(seed)) % 100) < commit_pct;  // oldest tag only
        commit       = (cmt_q.size() > 0) ? cmt_q[0] : '0;
        #1;
        took    = in_valid && in_ready;
        s_move  = !issue_valid || issue_ready;  // issue register may load
        s_xfer  = issue_valid && issue_ready && !f;
        s_issue = issue;
        @(posedge clk);
        #1;
        cap = s_move && !f && issue_valid;  // stage 2 captured at this edge
        cw  = '0;
        if (f) begin
            model_flush();
            acc_q.delete();
            exp_q.delete();
            cmt_q.delete();
            in_flight = 0;
        end else begin
            if (s_xfer) take_issue(s_issue);
            if (cap) begin
                assert (acc_q.size() > 0)
                    else note_failure("a micro-op was issued that was never accepted");
                assert (in_flight < ROB_DEPTH)
                    else note_failure("a tag was taken while all eight were outstanding");
                cap = acc_q.size() > 0;
                if (cap) cw = acc_q.pop_front();
            end
            model_edge(commit_valid, commit, cap, cw, e);
            if (cap) begin
                exp_q.push_back(e);
                in_flight++;
            end
            if (commit_valid) begin
                cmt_q.delete(0);
                in_flight--;
            end
            if (took) acc_q.push_back(w);
        end
        @(negedge clk);
    endtask

    task automatic send_word(input logic [31:0] w);
        bit took;
        took = 1'b0;
        if ($random(seed) & 1) step(1'b0, 1'b0, 32'h0, took);  // idle cycle now and then
        took = 1'b0;
        while (!took) step(1'b0, 1'b1, w, took);
    endtask

    // run until every accepted word is issued, and all tags returned if retire is set
    task automatic drain(input bit retire);
        bit took;
        if (retire) commit_pct = 100;
        while (acc_q.size() > 0 || exp_q.size() > 0 || (retire && cmt_q.size() > 0)) begin
            step(1'b0, 1'b0, 32'h0, took);
        end
    endtask

    task automatic end_test(input string name, input int base);
        $display("test %-10s finished: %0d issued, %0d errors so far", name, issued - base,
                 errors);
    endtask

    // watchdog allows 20 cycles per word plus margin
    initial begin
        #((N_TOTAL * 20 + 200) * 10);
        $display("Timeout: the run did not finish within %0d cycles", N_TOTAL * 20 + 200);
        $display("Checks failed");
        $finish;
    end

    initial begin
        bit took;
        int base;
        int k;
        reset        = 1'b1;
        flush        = 1'b0;
        in_valid     = 1'b0;
        in_word      = '0;
        issue_ready  = 1'b0;
        commit_valid = 1'b0;
        commit       = '0;
        model_flush();
        repeat (16) @(negedge clk);
        reset = 1'b0;
        assert (in_ready && !issue_valid) else note_failure("wrong handshake state after reset");

        base       = issued;  // decode, dependencies and back-pressure
        ready_pct  = 60;
        commit_pct = 50;
        repeat (N_RAND) send_word(random_word());
        drain(1'b1);
        end_test("random", base);

        base       = issued;  // two writers to x5 committed one at a time
        ready_pct  = 100;
        commit_pct = 0;
        send_word(addi_word(5'd5, 5'd0));
        send_word(addi_word(5'd5, 5'd5));
        drain(1'b0);
        commit_pct = 100;
        step(1'b0, 1'b0, 32'h0, took);  // older write retires
        commit_pct = 0;
        send_word(add_word(5'd6, 5'd5, 5'd5));  // still pending on the younger tag
        drain(1'b0);
        commit_pct = 100;
        step(1'b0, 1'b0, 32'h0, took);
        commit_pct = 0;
        send_word(add_word(5'd7, 5'd5, 5'd0));  // x5 free now
        drain(1'b1);
        end_test("waw_commit", base);

        step(1'b1, 1'b0, 32'h0, took);  // ring back to tag 0
        base       = issued;
        ready_pct  = 100;
        commit_pct = 0;
        k          = 0;
        repeat (30) begin
            step(1'b0, 1'b1, addi_word(5'(k % 7 + 1), 5'd0), took);
            if (took) k++;
        end
        assert (issued - base == ROB_DEPTH && in_flight == ROB_DEPTH)
            else note_failure("issue did not stall with eight tags outstanding");
        commit_pct = 50;
        drain(1'b0);  // the held word goes once a tag is back
        send_word(addi_word(5'd3, 5'd1));
        drain(1'b1);
        end_test("tag_ring", base);

        base       = issued;
        ready_pct  = 50;
        commit_pct = 40;
        repeat (20) send_word(random_word());
        step(1'b1, 1'b0, 32'h0, took);
        assert (!issue_valid) else note_failure("issue_valid stayed high after a flush");
        repeat (20) send_word(random_word());
        drain(1'b1);
        end_test("flush", base);

        assert (in_ready && !issue_valid)
            else note_failure("the DUT did not return to idle after the last retire");
        $display("summary: %0d transfers checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+bench
src/isa_pkg.sv
src/rename_pkg.sv
src/instr_decode.sv
src/rob_tag_alloc.sv
src/reg_status_table.sv
src/issue_stage_top.sv
bench/tb_clock.sv
bench/issue_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the issue stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module issue_tb -f verilog.f \
    -Mdir obj_dir -o issue_sim

./obj_dir/issue_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log; then
    exit 1
fi
if ! grep -q "All checks passed" sim.log; then
    exit 1
fi
exit 0
